//--- hdl/flash_pkg.sv
`default_nettype none

package flash_pkg;

	localparam int HOST_AW = 4;
	localparam int HOST_DW = 16;

	localparam logic [3:0] REG_ADDR_LO   = 4'd0;
	localparam logic [3:0] REG_ADDR_HI   = 4'd1;
	localparam logic [3:0] REG_CMD       = 4'd2;
	localparam logic [3:0] REG_DATA      = 4'd3;
	localparam logic [3:0] REG_STATUS    = 4'd4;
	localparam logic [3:0] REG_DMA_ADDR  = 4'd5;
	localparam logic [3:0] REG_DMA_COUNT = 4'd6;

	localparam logic [7:0] CMD_READ = 8'h03;
	localparam logic [7:0] CMD_WAKE = 8'hAB;

	// Clock cycles per SPI bit and the tick on which SCK rises.
	localparam int FAST_TICKS    = 2;
	localparam int SLOW_TICKS    = 8;
	localparam int SCK_RISE_FAST = 0;
	localparam int SCK_RISE_SLOW = 4;

	localparam int CMD_BITS  = 8;
	localparam int ADDR_BITS = 24;
	localparam int WORD_BITS = 16;

	typedef struct packed {
		logic [22:0] flash_addr;
		logic [15:0] dma_addr;
		logic [15:0] dma_count;
	} flash_cfg_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} dma_wr_t;

	typedef struct packed {
		logic [23:0] shift;	// Left aligned, MSB goes out first.
		logic [4:0] bits;
		logic slow;
		logic rx;
	} spi_phase_t;

	typedef enum logic [2:0] {
		idle,
		send_cmd,
		send_addr,
		get_data,
		mem_wr,
		finish,
		send_wake
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- hdl/flash_regs.sv
`timescale 1ns/1ps
`default_nettype none

module flash_regs (
	input wire CLK,
	input wire RSTb,
	input wire [flash_pkg::HOST_AW-1:0] address,
	input wire [flash_pkg::HOST_DW-1:0] data_in,
	input wire wr,
	input wire start,
	input wire finish,
	input wire [15:0] rx_word,
	output logic [flash_pkg::HOST_DW-1:0] data_out,
	output flash_pkg::flash_cfg_t cfg,
	output logic go,
	output logic wake
);

	logic [15:0] addr_lo;
	logic [6:0] addr_hi;
	logic [15:0] dma_addr;
	logic [15:0] dma_count;
	logic done;
	logic cmd_wr;

	assign cmd_wr = wr && (address == flash_pkg::REG_CMD);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			addr_lo   <= '0;
			addr_hi   <= '0;
			dma_addr  <= '0;
			dma_count <= '0;
			go        <= 1'b0;
			wake      <= 1'b0;
		end else begin
			go   <= cmd_wr & data_in[0];
			wake <= cmd_wr & data_in[1] & ~data_in[0];	// Go wins.
			if (wr) begin
				case (address)
					flash_pkg::REG_ADDR_LO:   addr_lo   <= data_in;
					flash_pkg::REG_ADDR_HI:   addr_hi   <= data_in[6:0];
					flash_pkg::REG_DMA_ADDR:  dma_addr  <= data_in;
					flash_pkg::REG_DMA_COUNT: dma_count <= data_in;
					default: ;
				endcase
			end
		end
	end

	// Done drops when a transaction starts and rises as it ends.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			done <= 1'b0;
		end else if (start) begin
			done <= 1'b0;
		end else if (finish) begin
			done <= 1'b1;
		end
	end

	always_comb begin
		cfg.flash_addr = {addr_hi, addr_lo};
		cfg.dma_addr   = dma_addr;
		cfg.dma_count  = dma_count;
	end

	always_comb begin
		case (address)
			flash_pkg::REG_DATA:   data_out = {rx_word[7:0], rx_word[15:8]};	// Flash byte order.
			flash_pkg::REG_STATUS: data_out = {15'd0, done};
			default:               data_out = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/spi_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bit_engine (
	input wire CLK,
	input wire RSTb,
	input wire phase_start,
	input wire flash_pkg::spi_phase_t phase,
	input wire hold_high,
	input wire miso,
	output logic phase_done,
	output logic [15:0] rx_word,
	output logic sck,
	output logic mosi
);

	logic busy;
	logic [2:0] tick;
	logic [4:0] bit_cnt;
	logic [4:0] bits_q;
	logic slow_q;
	logic rx_q;
	logic [23:0] shift_q;
	logic rise_tick;
	logic last_tick;
	logic last_bit;

	always_comb begin
		if (slow_q) begin
			rise_tick = (tick == 3'(flash_pkg::SCK_RISE_SLOW));
			last_tick = (tick == 3'(flash_pkg::SLOW_TICKS - 1));
		end else begin
			rise_tick = (tick == 3'(flash_pkg::SCK_RISE_FAST));
			last_tick = (tick == 3'(flash_pkg::FAST_TICKS - 1));
		end
		last_bit = (bit_cnt == bits_q - 5'd1);
	end

	assign phase_done = busy & last_tick & last_bit;
	assign mosi       = busy & ~rx_q & shift_q[23];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy    <= 1'b0;
			tick    <= '0;
			bit_cnt <= '0;
			bits_q  <= '0;
			slow_q  <= 1'b0;
			rx_q    <= 1'b0;
			sck     <= 1'b0;
			rx_word <= '0;
		end else begin
			if (busy) begin
				tick <= last_tick ? 3'd0 : tick + 3'd1;
				if (rise_tick) begin
					sck <= 1'b1;
					if (rx_q)
						rx_word <= {rx_word[14:0], miso};	// Sampled as SCK rises.
				end
				if (last_tick) begin
					sck     <= 1'b0;
					shift_q <= {shift_q[22:0], 1'b0};
					bit_cnt <= bit_cnt + 5'd1;
					if (last_bit)
						busy <= 1'b0;
				end
			end

			// A new phase may be loaded on the last tick of the previous one.
			if (phase_start) begin
				busy    <= 1'b1;
				tick    <= '0;
				bit_cnt <= '0;
				bits_q  <= phase.bits;
				slow_q  <= phase.slow;
				rx_q    <= phase.rx;
				shift_q <= phase.shift;
				sck     <= 1'b0;
			end

			if (hold_high)
				sck <= 1'b1;	// Left high after the transaction.
		end
	end

endmodule

`default_nettype wire

//--- hdl/flash_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module flash_read_ctrl (
	input wire CLK,
	input wire RSTb,
	input wire go,
	input wire wake,
	input wire flash_pkg::flash_cfg_t cfg,
	input wire phase_done,
	input wire [15:0] rx_word,
	input wire wready,
	output logic start,
	output logic finish,
	output logic phase_start,
	output flash_pkg::spi_phase_t phase,
	output logic hold_high,
	output logic csb,
	output logic wvalid,
	output flash_pkg::dma_wr_t dma,
	output logic irq
);

	flash_pkg::ctrl_state_e state;
	logic [15:0] count_q;
	flash_pkg::spi_phase_t cmd_phase;
	flash_pkg::spi_phase_t addr_phase;
	flash_pkg::spi_phase_t data_phase;
	flash_pkg::spi_phase_t wake_phase;

	always_comb begin
		cmd_phase.shift  = {flash_pkg::CMD_READ, 16'h0000};
		cmd_phase.bits   = 5'(flash_pkg::CMD_BITS);
		cmd_phase.slow   = 1'b0;
		cmd_phase.rx     = 1'b0;

		addr_phase.shift = {1'b0, cfg.flash_addr};
		addr_phase.bits  = 5'(flash_pkg::ADDR_BITS);
		addr_phase.slow  = 1'b0;
		addr_phase.rx    = 1'b0;

		data_phase.shift = '0;
		data_phase.bits  = 5'(flash_pkg::WORD_BITS);
		data_phase.slow  = 1'b0;
		data_phase.rx    = 1'b1;

		wake_phase.shift = {flash_pkg::CMD_WAKE, 16'h0000};
		wake_phase.bits  = 5'(flash_pkg::CMD_BITS);
		wake_phase.slow  = 1'b1;	// Device is still asleep, so go slow.
		wake_phase.rx    = 1'b0;
	end

	// Phases chain straight on from phase_done so no SPI cycle is lost.
	always_comb begin
		phase_start = 1'b0;
		phase       = data_phase;
		case (state)
			flash_pkg::send_cmd: begin
				phase = cmd_phase;
				if (start) begin
					phase_start = 1'b1;
				end else if (phase_done) begin
					phase       = addr_phase;
					phase_start = 1'b1;
				end
			end
			flash_pkg::send_wake: begin
				phase       = wake_phase;
				phase_start = start;
			end
			flash_pkg::send_addr: phase_start = phase_done;
			flash_pkg::mem_wr:    phase_start = wready && (count_q != 16'd0);
			default: ;
		endcase
	end

	assign finish    = (state == flash_pkg::finish);
	assign hold_high = finish;
	assign irq       = finish;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state  <= flash_pkg::idle;
			start  <= 1'b0;
			csb    <= 1'b1;
			wvalid <= 1'b0;
		end else begin
			start <= 1'b0;
			if (start)
				csb <= 1'b0;

			case (state)
				flash_pkg::idle: begin
					if (go) begin
						state   <= flash_pkg::send_cmd;
						start   <= 1'b1;
						dma.addr <= cfg.dma_addr;
						count_q <= cfg.dma_count;
					end else if (wake) begin
						state <= flash_pkg::send_wake;
						start <= 1'b1;
					end
				end
				flash_pkg::send_cmd: begin
					if (phase_done)
						state <= flash_pkg::send_addr;
				end
				flash_pkg::send_addr: begin
					if (phase_done)
						state <= flash_pkg::get_data;
				end
				flash_pkg::get_data: begin
					if (phase_done) begin
						state    <= flash_pkg::mem_wr;
						wvalid   <= 1'b1;
						dma.data <= {rx_word[7:0], rx_word[15:8]};
					end
				end
				flash_pkg::mem_wr: begin
					if (wready) begin
						wvalid   <= 1'b0;
						dma.addr <= dma.addr + 16'd1;
						count_q  <= count_q - 16'd1;
						if (count_q == 16'd0)
							state <= flash_pkg::finish;	// Count was the last index.
						else
							state <= flash_pkg::get_data;
					end
				end
				flash_pkg::send_wake: begin
					if (phase_done)
						state <= flash_pkg::finish;
				end
				flash_pkg::finish: begin
					csb   <= 1'b1;
					state <= flash_pkg::idle;
				end
				default: state <= flash_pkg::idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/spi_flash.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash (
	input wire CLK,
	input wire RSTb,
	input wire [flash_pkg::HOST_AW-1:0] address,
	input wire [flash_pkg::HOST_DW-1:0] data_in,
	output logic [flash_pkg::HOST_DW-1:0] data_out,
	input wire wr,
	output logic mosi,
	input wire miso,
	output logic sck,
	output logic csb,
	output logic wvalid,
	input wire wready,
	output logic [15:0] memory_address,
	output logic [15:0] memory_data,
	output logic irq
);

	flash_pkg::flash_cfg_t cfg;
	flash_pkg::spi_phase_t phase;
	flash_pkg::dma_wr_t dma;
	logic go;
	logic wake;
	logic start;
	logic finish;
	logic phase_start;
	logic phase_done;
	logic hold_high;
	logic [15:0] rx_word;

	assign memory_address = dma.addr;
	assign memory_data    = dma.data;

	flash_regs i_flash_regs (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.address  (address),
		.data_in  (data_in),
		.wr       (wr),
		.start    (start),
		.finish   (finish),
		.rx_word  (rx_word),
		.data_out (data_out),
		.cfg      (cfg),
		.go       (go),
		.wake     (wake)
	);

	flash_read_ctrl i_flash_read_ctrl (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.go          (go),
		.wake        (wake),
		.cfg         (cfg),
		.phase_done  (phase_done),
		.rx_word     (rx_word),
		.wready      (wready),
		.start       (start),
		.finish      (finish),
		.phase_start (phase_start),
		.phase       (phase),
		.hold_high   (hold_high),
		.csb         (csb),
		.wvalid      (wvalid),
		.dma         (dma),
		.irq         (irq)
	);

	spi_bit_engine i_spi_bit_engine (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.phase_start (phase_start),
		.phase       (phase),
		.hold_high   (hold_high),
		.miso        (miso),
		.phase_done  (phase_done),
		.rx_word     (rx_word),
		.sck         (sck),
		.mosi        (mosi)
	);

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;	// 4 ns period.
	end

	initial begin
		RSTb = 1'b0;
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
	end

endmodule

`default_nettype wire

//--- test/flash_device_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_device_model (
	input wire sck,
	input wire csb,
	input wire mosi,
	output logic miso,
	output logic [31:0] cmd_word
);

	logic [7:0] mem [0:255];
	logic [7:0] base;
	integer seed;
	integer cnt;
	integer i;
	integer d;

	initial begin
		seed = 28;
		for (i = 0; i < 256; i = i + 1)
			mem[i] = 8'($random(seed));
		miso     = 1'b0;
		cmd_word = '0;
		cnt      = 0;
	end

	always @(negedge csb) begin
		cnt      = 0;
		cmd_word = '0;
	end

	// First 32 bits hold the opcode and the address, MSB first.
	always @(posedge sck) begin
		if (!csb) begin
			if (cnt < 32)
				cmd_word[31 - cnt] = mosi;
			cnt = cnt + 1;
		end
	end

	always @(negedge sck) begin
		if (!csb && cnt >= 32) begin
			d    = cnt - 32;
			base = cmd_word[7:0] + 8'(d / 8);	// Wraps in 256.
			miso = mem[base][7 - (d % 8)];
		end
	end

endmodule

`default_nettype wire

//--- test/spi_flash_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_asserts (
	input wire CLK,
	input wire RSTb,
	input wire wvalid,
	input wire wready,
	input wire [15:0] memory_address,
	input wire [15:0] memory_data,
	input wire csb,
	input wire irq,
	input wire flash_pkg::ctrl_state_e state
);

	wvalid_held: assert property (@(posedge CLK) disable iff (!RSTb)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped without wready");

	dma_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		wvalid && !wready |=> $stable(memory_address) && $stable(memory_data))
		else $error("DMA address or data changed while waiting");

	csb_idle: assert property (@(posedge CLK) disable iff (!RSTb)
		state == flash_pkg::idle |-> csb)
		else $error("csb low while the sequencer is idle");

	irq_pulse: assert property (@(posedge CLK) disable iff (!RSTb)
		irq |=> !irq)
		else $error("irq longer than one cycle");

endmodule

bind spi_flash spi_flash_asserts i_spi_flash_asserts (
	.CLK            (CLK),
	.RSTb           (RSTb),
	.wvalid         (wvalid),
	.wready         (wready),
	.memory_address (memory_address),
	.memory_data    (memory_data),
	.csb            (csb),
	.irq            (irq),
	.state          (i_flash_read_ctrl.state)
);

`default_nettype wire

//--- test/tb_spi_flash.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash;

	localparam int MAX_STALL = 7;
	localparam int WORD_CYC  = 32 + 1 + MAX_STALL;
	localparam int TXN_CYC   = 100 + 16 + 48 + 16 * WORD_CYC;
	localparam int LIMIT     = 20 * TXN_CYC + 500;

	wire CLK;
	wire RSTb;
	logic [3:0] address;
	logic [15:0] data_in;
	logic [15:0] data_out;
	logic wr;
	logic mosi;
	logic miso;
	logic sck;
	logic csb;
	logic wvalid;
	logic wready;
	logic [15:0] memory_address;
	logic [15:0] memory_data;
	logic irq;
	logic [31:0] cmd_word;

	logic [7:0] ref_mem [0:255];
	logic [15:0] wr_addr_q[$];
	logic [15:0] wr_data_q[$];
	integer seed;
	integer ref_seed;
	integer cycles;
	integer stall;
	integer irq_count;
	integer wvalid_count;
	integer fall_count;
	logic sck_q;
	logic csb_q;

	tb_clock_gen i_clock_gen (.CLK(CLK), .RSTb(RSTb));

	flash_device_model i_flash (
		.sck(sck), .csb(csb), .mosi(mosi), .miso(miso), .cmd_word(cmd_word)
	);

	spi_flash i_spi_flash (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.address        (address),
		.data_in        (data_in),
		.data_out       (data_out),
		.wr             (wr),
		.mosi           (mosi),
		.miso           (miso),
		.sck            (sck),
		.csb            (csb),
		.wvalid         (wvalid),
		.wready         (wready),
		.memory_address (memory_address),
		.memory_data    (memory_data),
		.irq            (irq)
	);

	task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [15:0] d);
		@(negedge CLK);
		address = a;
		data_in = d;
		wr      = 1'b1;
		@(negedge CLK);
		wr      = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] a, output logic [15:0] v);
		@(negedge CLK);
		address = a;
		@(posedge CLK);
		v = data_out;
	endtask

	task automatic wait_irq(input integer target);
		while (irq_count < target)
			@(posedge CLK);
		repeat (3) @(negedge CLK);
		check(32'(irq_count), 32'(target), "irq pulse count");
		check(32'(csb), 32'd1, "csb high after irq");
	endtask

	task automatic run_read;
		integer r;
		integer k;
		integer base_irq;
		logic [22:0] fa;
		logic [15:0] da;
		logic [15:0] cnt;
		logic [15:0] v;
		logic [15:0] exp_data;
		r   = $random(seed);
		fa  = 23'(r);
		r   = $random(seed);
		da  = 16'(r);
		r   = $random(seed);
		cnt = 16'(r & 15);
		write_reg(flash_pkg::REG_ADDR_LO, fa[15:0]);
		write_reg(flash_pkg::REG_ADDR_HI, {9'd0, fa[22:16]});
		write_reg(flash_pkg::REG_DMA_ADDR, da);
		write_reg(flash_pkg::REG_DMA_COUNT, cnt);
		wr_addr_q.delete();
		wr_data_q.delete();
		base_irq = irq_count;
		write_reg(flash_pkg::REG_CMD, 16'h0001);
		repeat (4) @(negedge CLK);
		read_reg(flash_pkg::REG_STATUS, v);
		check(32'(v), 32'd0, "status during read");
		write_reg(flash_pkg::REG_CMD, 16'h0003);	// Must be ignored.
		wait_irq(base_irq + 1);
		check(cmd_word, {flash_pkg::CMD_READ, 1'b0, fa}, "command and address on MOSI");
		check(32'(wr_addr_q.size()), 32'(cnt) + 32'd1, "DMA write count");
		exp_data = '0;
		for (k = 0; k <= int'(cnt); k = k + 1) begin
			exp_data = {ref_mem[fa[7:0] + 8'(2 * k + 1)], ref_mem[fa[7:0] + 8'(2 * k)]};
			check(32'(wr_addr_q[k]), 32'(da + 16'(k)), "DMA write address");
			check(32'(wr_data_q[k]), 32'(exp_data), "DMA write data");
		end
		read_reg(flash_pkg::REG_STATUS, v);
		check(32'(v), 32'd1, "status after read");
		read_reg(flash_pkg::REG_DATA, v);
		check(32'(v), 32'(exp_data), "data register");
	endtask

	task automatic run_wake;
		integer base_irq;
		integer base_wv;
		integer base_falls;
		logic [15:0] v;
		base_irq   = irq_count;
		base_wv    = wvalid_count;
		base_falls = fall_count;
		write_reg(flash_pkg::REG_CMD, 16'h0002);
		wait_irq(base_irq + 1);
		check(32'(fall_count - base_falls), 32'd8, "SCK pulses in wake");
		check(32'(cmd_word[31:24]), 32'(flash_pkg::CMD_WAKE), "wake opcode on MOSI");
		check(32'(wvalid_count), 32'(base_wv), "wvalid during wake");
		read_reg(flash_pkg::REG_STATUS, v);
		check(32'(v), 32'd1, "status after wake");
	endtask

	always @(negedge CLK) begin
		if (stall >= MAX_STALL) begin
			wready = 1'b1;	// Bounds the DMA wait.
		end else begin
			wready = 1'($random(seed));
		end
		stall = wready ? 0 : stall + 1;
	end

	always @(posedge CLK) begin
		if (RSTb) begin
			if (wvalid && wready) begin
				wr_addr_q.push_back(memory_address);
				wr_data_q.push_back(memory_data);
			end
			if (wvalid)
				wvalid_count <= wvalid_count + 1;
			if (irq)
				irq_count <= irq_count + 1;
			if (!csb_q && !csb && sck_q && !sck)
				fall_count <= fall_count + 1;
		end
		sck_q <= sck;
		csb_q <= csb;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout: the run passed its cycle limit at %0t ns", $time);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		integer i;
		logic [15:0] v;
		address      = '0;
		data_in      = '0;
		wr           = 1'b0;
		wready       = 1'b0;
		seed         = 28;
		ref_seed     = 28;
		cycles       = 0;
		stall        = 0;
		irq_count    = 0;
		wvalid_count = 0;
		fall_count   = 0;
		sck_q        = 1'b0;
		csb_q        = 1'b1;
		for (i = 0; i < 256; i = i + 1)
			ref_mem[i] = 8'($random(ref_seed));
		@(posedge RSTb);
		for (i = 0; i < 12; i = i + 1)
			run_read();
		run_wake();
		run_read();
		// Write-only and unmapped indices read zero while the registers hold data.
		for (i = 0; i < 16; i = i + 1) begin
			if (4'(i) != flash_pkg::REG_DATA && 4'(i) != flash_pkg::REG_STATUS) begin
				read_reg(4'(i), v);
				check(32'(v), 32'd0, "unmapped register");
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hdl/flash_pkg.sv
hdl/flash_regs.sv
hdl/spi_bit_engine.sv
hdl/flash_read_ctrl.sv
hdl/spi_flash.sv
test/tb_clock_gen.sv
test/flash_device_model.sv
test/spi_flash_asserts.sv
test/tb_spi_flash.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_spi_flash
FILELIST  = project.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJDIR)
